/* Makefile */
# Verilator build for the spi io board controller

VERILATOR ?= verilator
TOP       ?= spi_io_tb
RTL_TOP   ?= spi_io_top
FILELIST  ?= spi_io_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "simulation ended without passing, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/spi_io_props.sv */
////////////////////////////////////////////////////////////////////////////
// bound checks for the board controller top
// reset quiet outputs, frame strobe width, idle chain strobes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module spi_io_props #(
  parameter int                  num_chan    = 4,
  parameter logic [num_chan-1:0] cs_polarity = 4'b0001
) (
  input logic                clk,
  input logic                rst_n,
  input logic                frame_valid,
  input logic                oe_4094,
  input logic                cs2,
  input logic [3:0]          leds,
  input logic [num_chan-1:0] chain_cs
);

  int fail_cnt = 0;  // failures seen so far, read at end of run

  // outputs dark on release and the cycle after
  reset_quiet_a: assert property (@(posedge clk) $rose(rst_n) |-> !oe_4094 && leds == 4'b0000)
    else begin
      $error("oe_4094 or leds not quiet at reset release");
      fail_cnt++;
    end

  reset_hold_a: assert property (@(posedge clk) $rose(rst_n) |=> !oe_4094 && leds == 4'b0000)
    else begin
      $error("oe_4094 or leds not quiet after reset release");
      fail_cnt++;
    end

  strobe_width_a: assert property (@(posedge clk) disable iff (!rst_n)
    frame_valid |=> !frame_valid)
    else begin
      $error("frame_valid high for two cycles");
      fail_cnt++;
    end

  // cs2 high, every strobe at its inactive level
  chain_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
    cs2 |-> chain_cs == ~cs_polarity)
    else begin
      $error("chain strobe active while cs2 is high");
      fail_cnt++;
    end

endmodule

bind spi_io_top spi_io_props #(.num_chan(num_chan), .cs_polarity(cs_polarity)) props_inst (
  .clk(clk), .rst_n(rst_n), .frame_valid(frame_valid), .oe_4094(oe_4094),
  .cs2(cs2), .leds(leds), .chain_cs(chain_cs)
);

`default_nettype wire

/* dv/spi_io_tb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the board controller top
// bit-banged spi frames, stimulus table, led mode and routing checks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module spi_io_tb;

  localparam int                  num_chan = 4;
  localparam logic [num_chan-1:0] cs_pol   = 4'b0001;
  localparam int                  hb_bits  = 4;
  localparam int                  hb_limit = 4 * (2 ** hb_bits); // blink/walk timeout
  localparam int chk_none = 0;
  localparam int chk_word = 1;  // compare read word
  localparam int chk_leds = 2;
  localparam int chk_oe   = 3;

  logic clk, rst_n, sck, ss, sdi, cs2, sdo, oe_4094;
  logic [num_chan-1:0] chain_miso, chain_cs, chain_clk, chain_mosi;
  logic [2:0]  hw_flags;
  logic [3:0]  leds;
  logic [31:0] rnd [4];
  logic [31:0] rd_word;

  // stimulus table with one entry per frame
  string       row_name [$];
  logic        row_wr   [$];
  logic [6:0]  row_addr [$];
  logic [31:0] row_data [$];
  int          row_chk  [$];
  logic [31:0] row_exp  [$];

  spi_io_top #(.num_chan(num_chan), .cs_polarity(cs_pol), .heartbeat_bits(hb_bits))
    spi_io_top_inst (
    .clk(clk), .rst_n(rst_n), .sck(sck), .ss(ss), .sdi(sdi), .cs2(cs2),
    .chain_miso(chain_miso), .hw_flags(hw_flags), .sdo(sdo), .chain_cs(chain_cs),
    .chain_clk(chain_clk), .chain_mosi(chain_mosi), .oe_4094(oe_4094), .leds(leds)
  );

  always #10 clk = ~clk;  // 20 ns period

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  // stop at the first bound assertion failure
  always @(posedge clk)
    if (spi_io_top_inst.props_inst.fail_cnt != 0)
      abort_run("a bound assertion failed");

  task automatic check_word(input string name, input spi_io_pkg::reg_word_u exp,
                            input spi_io_pkg::reg_word_u act);
    if (act.raw !== exp.raw)
      abort_run($sformatf("FAIL %s expected %08h actual %08h", name, exp.raw, act.raw));
  endtask

  task automatic check_leds(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp)
      abort_run($sformatf("FAIL %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_route(input string name, input logic [num_chan-1:0] exp,
                             input logic [num_chan-1:0] act);
    if (act !== exp)
      abort_run($sformatf("FAIL %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("FAIL %s expected %b actual %b", name, exp, act));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;  // drive and sample point
  endtask

  task automatic wait_frame();
    int n;
    n = 0;
    while (spi_io_top_inst.frame_valid !== 1'b1) begin
      if (n == 12)
        abort_run("frame strobe never came after ss went high");
      next_cycle();
      n++;
    end
  endtask

  // 40 bits msb first at 4 clk per sck half period
  task automatic run_frame(input logic wr, input logic [6:0] addr, input logic [31:0] data,
                           output logic [31:0] rd);
    logic [39:0] bits;
    bits = {wr, addr, data};
    rd = '0;
    ss = 1'b0;
    repeat (4) next_cycle();
    for (int i = 39; i >= 0; i--) begin
      sck = 1'b0;
      sdi = bits[i];
      repeat (4) next_cycle();
      if (i < 32)
        rd = {rd[30:0], sdo};  // data phase
      sck = 1'b1;
      repeat (4) next_cycle();
    end
    sck = 1'b0;
    repeat (4) next_cycle();
    ss = 1'b1;
    wait_frame();
    repeat (3) next_cycle();  // register update plus led flop
  endtask

  task automatic add_row(input string name, input logic wr, input logic [6:0] addr,
                         input logic [31:0] data, input int chk, input logic [31:0] exp);
    row_name.push_back(name);
    row_wr.push_back(wr);
    row_addr.push_back(addr);
    row_data.push_back(data);
    row_chk.push_back(chk);
    row_exp.push_back(exp);
  endtask

  task automatic build_table();
    add_row("ident_read", 1'b0, spi_io_pkg::addr_ident, rnd[0], chk_word,
            spi_io_pkg::ident_value);
    add_row("mode_write", 1'b1, spi_io_pkg::addr_mode, rnd[0], chk_none, 0);
    add_row("mode_read", 1'b0, spi_io_pkg::addr_mode, 0, chk_word, {29'd0, rnd[0][2:0]});
    add_row("led_write", 1'b1, spi_io_pkg::addr_led, rnd[1], chk_none, 0);
    add_row("led_read", 1'b0, spi_io_pkg::addr_led, 0, chk_word, {28'd0, rnd[1][3:0]});
    add_row("mux_write", 1'b1, spi_io_pkg::addr_spi_mux, rnd[2], chk_none, 0);
    add_row("mux_read", 1'b0, spi_io_pkg::addr_spi_mux, 0, chk_word, {28'd0, rnd[2][3:0]});
    add_row("oe_set", 1'b1, spi_io_pkg::addr_oe_4094, rnd[3] | 32'd1, chk_oe, 1);
    add_row("oe_read", 1'b0, spi_io_pkg::addr_oe_4094, 0, chk_word, 32'd1);
    add_row("oe_clear", 1'b1, spi_io_pkg::addr_oe_4094, rnd[3] & ~32'd1, chk_oe, 0);
    add_row("mode_zero", 1'b1, spi_io_pkg::addr_mode, 0, chk_leds, {28'd0, rnd[1][3:0]});
    add_row("led_known", 1'b1, spi_io_pkg::addr_led, 32'h5, chk_leds, 32'h5);
    // set bit 1 and clear bit 2 of 0101 gives 0011
    add_row("led_set_clr", 1'b1, spi_io_pkg::addr_led_modify, 32'h0004_0002, chk_leds, 32'h3);
    // both halves on bits 0 and 3 toggle to 1010
    add_row("led_toggle", 1'b1, spi_io_pkg::addr_led_modify, 32'h0009_0009, chk_leds, 32'ha);
    // only bits above the four leds so nothing moves
    add_row("led_hold", 1'b1, spi_io_pkg::addr_led_modify, 32'hfff0_fff0, chk_leds, 32'ha);
    add_row("status_mode0", 1'b0, spi_io_pkg::addr_status, 0, chk_word, 32'h05);
    add_row("mode_on", 1'b1, spi_io_pkg::addr_mode, 32'd7, chk_leds, 32'hf);
    add_row("status_mode7", 1'b0, spi_io_pkg::addr_status, 0, chk_word, 32'h75);
    add_row("mode_off", 1'b1, spi_io_pkg::addr_mode, 32'd1, chk_leds, 32'h0);
    add_row("sel_chain2", 1'b1, spi_io_pkg::addr_spi_mux, 32'h4, chk_none, 0);
    add_row("unknown_read", 1'b0, 7'h2a, rnd[2], chk_word, 32'h0);
  endtask

  task automatic watch_blink();
    int   n;
    logic seen_off, seen_on;
    n = 0;
    seen_off = 1'b0;
    seen_on = 1'b0;
    while (!(seen_off && seen_on)) begin
      if (n == hb_limit)
        abort_run("blink mode never showed both led states");
      if (leds == 4'b0000)
        seen_off = 1'b1;
      else if (leds == 4'b1111)
        seen_on = 1'b1;
      else
        check_leds("mode2_blink", 4'b1111, leds);  // partial pattern
      next_cycle();
      n++;
    end
  endtask

  task automatic watch_walk();
    int         n;
    logic [3:0] first;
    n = 0;
    first = leds;
    if (!$onehot(leds))
      abort_run("walking pattern does not show a single lit bit");
    while (leds == first) begin
      if (n == hb_limit)
        abort_run("walking bit never moved");
      next_cycle();
      n++;
      if (!$onehot(leds))
        abort_run("walking pattern lost its single lit bit");
    end
  endtask

  // chain 2 selected by the table
  task automatic check_routing();
    logic [num_chan-1:0] sel, exp_cs;
    sel = 4'b0100;
    for (int i = 0; i < num_chan; i++)
      exp_cs[i] = sel[i] ? cs_pol[i] : ~cs_pol[i];  // active level only when picked
    cs2 = 1'b0;
    next_cycle();
    check_route("route_cs_active", exp_cs, chain_cs);
    check_route("route_clk_low", '0, chain_clk);
    sck = 1'b1;
    sdi = 1'b1;
    next_cycle();
    check_route("route_clk_pulse", sel, chain_clk);
    check_route("route_mosi_pulse", sel, chain_mosi);
    sck = 1'b0;
    sdi = 1'b0;
    next_cycle();
    check_route("route_clk_back", '0, chain_clk);
    check_route("route_mosi_back", '0, chain_mosi);
    chain_miso = sel;
    next_cycle();
    check_flag("route_miso_sel", 1'b1, sdo);
    chain_miso = ~sel;  // only unselected chains drive
    next_cycle();
    check_flag("route_miso_other", 1'b0, sdo);
    cs2 = 1'b1;
    chain_miso = '0;
    next_cycle();
    check_route("route_cs_idle", ~cs_pol, chain_cs);
    check_flag("route_sdo_idle", 1'b0, sdo);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    sck = 1'b0;
    ss = 1'b1;
    sdi = 1'b0;
    cs2 = 1'b1;
    chain_miso = '0;
    hw_flags = 3'b101;
    rnd[0] = $urandom(9896);  // seeds the generator
    for (int i = 1; i < 4; i++)
      rnd[i] = $urandom();
    build_table();
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    next_cycle();
    check_leds("reset_leds", 4'b0000, leds);
    check_flag("reset_oe", 1'b0, oe_4094);
    for (int r = 0; r < row_name.size(); r++) begin
      run_frame(row_wr[r], row_addr[r], row_data[r], rd_word);
      case (row_chk[r])
        chk_word: check_word(row_name[r], row_exp[r], rd_word);
        chk_leds: check_leds(row_name[r], row_exp[r][3:0], leds);
        chk_oe:   check_flag(row_name[r], row_exp[r][0], oe_4094);
        default: ;
      endcase
    end
    run_frame(1'b1, spi_io_pkg::addr_mode, 32'd2, rd_word);
    watch_blink();
    run_frame(1'b1, spi_io_pkg::addr_mode, 32'd3, rd_word);
    watch_walk();
    check_routing();
    if (spi_io_top_inst.props_inst.fail_cnt == 0) begin
      $display("TEST PASS");
      $finish;
    end else
      abort_run("a bound assertion failed");
  end

endmodule

`default_nettype wire

/* spi_io_top.f */
verilog/spi_io_pkg.sv
verilog/spi_frame_shift.sv
verilog/register_bank.sv
verilog/spi_route_mux.sv
verilog/led_mode_mux.sv
verilog/spi_io_top.sv
dv/spi_io_props.sv
dv/spi_io_tb.sv

/* verilog/led_mode_mux.sv */
////////////////////////////////////////////////////////////////////////////
// led drive
// heartbeat counter and tick, blink flop, walking bit,
// 8 way source select by mode
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module led_mode_mux #(
  parameter int heartbeat_bits = 24
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [2:0] mode,
  input  logic [3:0] led_reg,
  output logic [3:0] leds
);

  logic [heartbeat_bits-1:0] hb_cnt;   // free running
  logic                      hb_tick;  // one clk every 2^heartbeat_bits
  logic                      blink;
  logic [3:0]                walk;     // one hot
  logic [7:0][3:0]           led_src;

  assign hb_tick = &hb_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hb_cnt <= '0;
      blink  <= 1'b0;
      walk   <= 4'b0001;
    end else begin
      hb_cnt <= hb_cnt + 1'b1;
      if (hb_tick) begin
        blink <= ~blink;
        walk  <= {walk[2:0], walk[3]};  // rotate left
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // source table, indexed by mode

  always_comb begin
    led_src    = '0;          // modes 1, 4, 5, 6 stay dark
    led_src[0] = led_reg;
    led_src[2] = {4{blink}};  // all four together
    led_src[3] = walk;
    led_src[7] = 4'b1111;
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      leds <= '0;
    else
      leds <= led_src[mode];
  end

endmodule

`default_nettype wire

/* verilog/register_bank.sv */
////////////////////////////////////////////////////////////////////////////
// control register bank
// write decode, mode/led/spi routing/4094 oe storage,
// led set/clear/toggle port, status and identity read mux
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module register_bank #(
  parameter int num_chan = 4
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  cmd_valid,   // after 8th bit
  input  logic [spi_io_pkg::cmd_write_bit-1:0]  cmd_addr,
  input  logic                                  cmd_write,
  input  logic                                  frame_valid, // full 40 bit frame
  input  logic [spi_io_pkg::cmd_write_bit-1:0]  frame_addr,
  input  logic                                  frame_write,
  input  logic [spi_io_pkg::data_bits-1:0]      frame_data,
  input  logic [2:0]                            hw_flags,
  output logic [spi_io_pkg::data_bits-1:0]      rd_data,
  output logic [2:0]                            mode,
  output logic [3:0]                            led_reg,
  output logic [num_chan-1:0]                   spi_sel,
  output logic                                  oe_4094
);

  spi_io_pkg::reg_word_u wr_word;
  logic [3:0] led_set, led_clr;
  logic [3:0] led_next;                         // led_reg after a modify write
  logic [spi_io_pkg::data_bits-1:0] rd_mux;

  assign wr_word.raw = frame_data;
  assign led_set = wr_word.modify[0][3:0];     // low half
  assign led_clr = wr_word.modify[1][3:0];     // high half

  // per bit: set, clear, both toggles, neither holds
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      case ({led_set[i], led_clr[i]})
        2'b10:   led_next[i] = 1'b1;
        2'b01:   led_next[i] = 1'b0;
        2'b11:   led_next[i] = ~led_reg[i];
        default: led_next[i] = led_reg[i];
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // write side

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mode    <= '0;
      led_reg <= '0;
      spi_sel <= '0;  // no chain routed
      oe_4094 <= 1'b0; // 4094 outputs off at power up
    end else if (frame_valid && frame_write) begin
      case (frame_addr)
        spi_io_pkg::addr_mode:       mode    <= frame_data[2:0];
        spi_io_pkg::addr_led:        led_reg <= frame_data[3:0];
        spi_io_pkg::addr_spi_mux:    spi_sel <= frame_data[num_chan-1:0];
        spi_io_pkg::addr_oe_4094:    oe_4094 <= frame_data[0];
        spi_io_pkg::addr_led_modify: led_reg <= led_next;
        default: ;                              // status, ident, unknown ignored
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read side, zero extended

  always_comb begin
    rd_mux = '0;
    case (cmd_addr)
      spi_io_pkg::addr_mode:    rd_mux[2:0] = mode;
      spi_io_pkg::addr_led:     rd_mux[3:0] = led_reg;
      spi_io_pkg::addr_spi_mux: rd_mux[num_chan-1:0] = spi_sel;
      spi_io_pkg::addr_oe_4094: rd_mux[0] = oe_4094;
      spi_io_pkg::addr_status: begin
        rd_mux[2:0] = hw_flags;
        rd_mux[6:4] = mode;
      end
      spi_io_pkg::addr_ident:   rd_mux = spi_io_pkg::ident_value;
      default:                  rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      rd_data <= '0;
    else if (cmd_valid && !cmd_write)
      rd_data <= rd_mux;  // into the shifter before the next falling sck
  end

endmodule

`default_nettype wire

/* verilog/spi_frame_shift.sv */
////////////////////////////////////////////////////////////////////////////
// spi slave in the clk domain
// pin synchronizers, 40 bit frame shifter, command and frame strobes,
// read word shift out on falling sck
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module spi_frame_shift (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  sck,
  input  logic                                  ss,          // active low
  input  logic                                  sdi,
  input  logic [spi_io_pkg::data_bits-1:0]      rd_data,     // from bank, one clk after cmd
  output logic                                  cmd_valid,
  output logic [spi_io_pkg::cmd_write_bit-1:0]  cmd_addr,
  output logic                                  cmd_write,
  output logic                                  frame_valid,
  output logic [spi_io_pkg::cmd_write_bit-1:0]  frame_addr,
  output logic                                  frame_write,
  output logic [spi_io_pkg::data_bits-1:0]      frame_data,
  output logic                                  frame_sdo
);

  localparam logic [5:0] cmd_last  = 6'(spi_io_pkg::cmd_bits - 1); // count before 8th bit
  localparam logic [5:0] cmd_cnt   = 6'(spi_io_pkg::cmd_bits);
  localparam logic [5:0] frame_cnt = 6'(spi_io_pkg::frame_bits);

  logic sck_meta, sck_sync, sck_prev;
  logic ss_meta, ss_sync, ss_prev;
  logic sdi_meta, sdi_sync;
  logic sck_rise, sck_fall, ss_rise;
  logic [5:0] bit_cnt;                                   // saturates at 63
  logic [spi_io_pkg::frame_bits-1:0] shift_in;
  logic [spi_io_pkg::cmd_bits-1:0] cmd_byte;
  logic [spi_io_pkg::data_bits-1:0] out_shift;
  logic cmd_valid_d;                                     // rd_data is valid now

  ////////////////////////////////////////////////////////////////////////////
  // synchronizers and edge detect

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sck_meta <= 1'b0;
      sck_sync <= 1'b0;
      sck_prev <= 1'b0;
      ss_meta  <= 1'b1;  // idle deselected
      ss_sync  <= 1'b1;
      ss_prev  <= 1'b1;
    end else begin
      sck_meta <= sck;
      sck_sync <= sck_meta;
      sck_prev <= sck_sync;
      ss_meta  <= ss;
      ss_sync  <= ss_meta;
      ss_prev  <= ss_sync;
    end
  end

  always_ff @(posedge clk) begin
    sdi_meta <= sdi;
    sdi_sync <= sdi_meta;  // same age as sck_sync
  end

  assign sck_rise = sck_sync & ~sck_prev & ~ss_sync;
  assign sck_fall = ~sck_sync & sck_prev & ~ss_sync;
  assign ss_rise  = ss_sync & ~ss_prev;

  // command byte as it stands once the 8th bit lands
  assign cmd_byte = {shift_in[spi_io_pkg::cmd_bits-2:0], sdi_sync};

  ////////////////////////////////////////////////////////////////////////////
  // bit counter, strobes

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt     <= '0;
      cmd_valid   <= 1'b0;
      cmd_valid_d <= 1'b0;
      frame_valid <= 1'b0;
    end else begin
      if (ss_sync)
        bit_cnt <= '0;
      else if (sck_rise && bit_cnt != '1)
        bit_cnt <= bit_cnt + 6'd1;
      cmd_valid   <= sck_rise && (bit_cnt == cmd_last);
      cmd_valid_d <= cmd_valid;
      frame_valid <= ss_rise && (bit_cnt == frame_cnt); // short or long frames dropped
    end
  end

  always_ff @(posedge clk) begin
    if (sck_rise)
      shift_in <= {shift_in[spi_io_pkg::frame_bits-2:0], sdi_sync}; // msb first
    if (sck_rise && bit_cnt == cmd_last) begin
      cmd_write <= cmd_byte[spi_io_pkg::cmd_write_bit];
      cmd_addr  <= cmd_byte[spi_io_pkg::cmd_write_bit-1:0];
    end
    if (ss_rise) begin
      frame_write <= shift_in[spi_io_pkg::data_bits + spi_io_pkg::cmd_write_bit];
      frame_addr  <= shift_in[spi_io_pkg::data_bits +: spi_io_pkg::cmd_write_bit];
      frame_data  <= shift_in[spi_io_pkg::data_bits-1:0];
    end
  end

  // read word out, bit 31 already on sdo at the first falling edge after cmd
  always_ff @(posedge clk) begin
    if (ss_sync)
      out_shift <= '0;
    else if (cmd_valid_d)
      out_shift <= rd_data;
    else if (sck_fall && bit_cnt > cmd_cnt)
      out_shift <= {out_shift[spi_io_pkg::data_bits-2:0], 1'b0};
  end

  assign frame_sdo = out_shift[spi_io_pkg::data_bits-1];

endmodule

`default_nettype wire

/* verilog/spi_io_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// spi io board controller shared definitions
// frame widths, register map, identity word
// register word union with raw and set/clear views
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package spi_io_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // frame layout

  localparam int cmd_bits      = 8;                    // command byte
  localparam int data_bits     = 32;                   // data word
  localparam int frame_bits    = cmd_bits + data_bits; // 40 bits per frame
  localparam int cmd_write_bit = 7;                    // msb of cmd, low 7 bits are addr

  ////////////////////////////////////////////////////////////////////////////
  // register map

  localparam logic [cmd_write_bit-1:0] addr_mode       = 7'h00;
  localparam logic [cmd_write_bit-1:0] addr_led        = 7'h01;
  localparam logic [cmd_write_bit-1:0] addr_spi_mux    = 7'h02;
  localparam logic [cmd_write_bit-1:0] addr_oe_4094    = 7'h03;
  localparam logic [cmd_write_bit-1:0] addr_status     = 7'h04; // read only
  localparam logic [cmd_write_bit-1:0] addr_led_modify = 7'h05; // write only, set/clear
  localparam logic [cmd_write_bit-1:0] addr_ident      = 7'h06; // read only

  localparam logic [data_bits-1:0] ident_value = 32'h5350_494f;

  // modify view: [1] is the clear half (31..16), [0] the set half (15..0)
  typedef union packed {
    logic [data_bits-1:0]                 raw;
    logic [1:0][(data_bits / 2)-1:0]      modify;
  } reg_word_u;

endpackage

`default_nettype wire

/* verilog/spi_io_top.sv */
////////////////////////////////////////////////////////////////////////////
// board controller top
// spi slave, register bank, chain routing, led modes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module spi_io_top #(
  parameter int                  num_chan       = 4,
  parameter logic [num_chan-1:0] cs_polarity    = 4'b0001, // 4094 strobe goes hi
  parameter int                  heartbeat_bits = 24
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sck,
  input  logic                ss,          // local register select, active low
  input  logic                sdi,
  input  logic                cs2,         // chain pass-through select, active low
  input  logic [num_chan-1:0] chain_miso,
  input  logic [2:0]          hw_flags,
  output logic                sdo,
  output logic [num_chan-1:0] chain_cs,
  output logic [num_chan-1:0] chain_clk,
  output logic [num_chan-1:0] chain_mosi,
  output logic                oe_4094,
  output logic [3:0]          leds
);

  logic                                  cmd_valid, cmd_write;
  logic [spi_io_pkg::cmd_write_bit-1:0]  cmd_addr, frame_addr;
  logic                                  frame_valid, frame_write;
  logic [spi_io_pkg::data_bits-1:0]      frame_data, rd_data;
  logic                                  frame_sdo;
  logic [2:0]                            mode;
  logic [3:0]                            led_reg;
  logic [num_chan-1:0]                   spi_sel;

  spi_frame_shift spi_frame_shift_inst (
    .clk(clk), .rst_n(rst_n), .sck(sck), .ss(ss), .sdi(sdi), .rd_data(rd_data),
    .cmd_valid(cmd_valid), .cmd_addr(cmd_addr), .cmd_write(cmd_write),
    .frame_valid(frame_valid), .frame_addr(frame_addr), .frame_write(frame_write),
    .frame_data(frame_data), .frame_sdo(frame_sdo)
  );

  register_bank #(.num_chan(num_chan)) register_bank_inst (
    .clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_addr(cmd_addr),
    .cmd_write(cmd_write), .frame_valid(frame_valid), .frame_addr(frame_addr),
    .frame_write(frame_write), .frame_data(frame_data), .hw_flags(hw_flags),
    .rd_data(rd_data), .mode(mode), .led_reg(led_reg), .spi_sel(spi_sel),
    .oe_4094(oe_4094)
  );

  // straight from the pins, no clk
  spi_route_mux #(.num_chan(num_chan), .cs_polarity(cs_polarity)) spi_route_mux_inst (
    .sck(sck), .sdi(sdi), .cs2(cs2), .ss(ss), .spi_sel(spi_sel),
    .chain_miso(chain_miso), .frame_sdo(frame_sdo), .chain_cs(chain_cs),
    .chain_clk(chain_clk), .chain_mosi(chain_mosi), .sdo(sdo)
  );

  led_mode_mux #(.heartbeat_bits(heartbeat_bits)) led_mode_mux_inst (
    .clk(clk), .rst_n(rst_n), .mode(mode), .led_reg(led_reg), .leds(leds)
  );

endmodule

`default_nettype wire

/* verilog/spi_route_mux.sv */
////////////////////////////////////////////////////////////////////////////
// cs2 pass-through of host spi to downstream chains
// per-chain strobe polarity, sdo source select
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module spi_route_mux #(
  parameter int                  num_chan    = 4,
  parameter logic [num_chan-1:0] cs_polarity = 4'b0001  // 1 = strobe active high
) (
  input  logic                sck,
  input  logic                sdi,
  input  logic                cs2,         // active low
  input  logic                ss,          // active low, local registers
  input  logic [num_chan-1:0] spi_sel,
  input  logic [num_chan-1:0] chain_miso,
  input  logic                frame_sdo,
  output logic [num_chan-1:0] chain_cs,
  output logic [num_chan-1:0] chain_clk,
  output logic [num_chan-1:0] chain_mosi,
  output logic                sdo
);

  logic [num_chan-1:0] chain_act;   // selected and cs2 asserted
  logic                chain_ret;   // combined return path

  assign chain_act = spi_sel & {num_chan{~cs2}};

  // active level when selected, inverse of polarity otherwise
  assign chain_cs = ~(chain_act ^ cs_polarity);

  // idle chains hold clk and mosi low
  assign chain_clk  = chain_act & {num_chan{sck}};
  assign chain_mosi = chain_act & {num_chan{sdi}};

  assign chain_ret = |(chain_miso & chain_act);

  ////////////////////////////////////////////////////////////////////////////
  // sdo source

  always_comb begin
    if (!ss)
      sdo = frame_sdo;      // local register read
    else if (!cs2)
      sdo = chain_ret;      // downstream chain
    else
      sdo = 1'b0;
  end

endmodule

`default_nettype wire
